/* dispatch_core.f */
source/dispatch_pkg.sv
source/instr_decoder.sv
source/reg_status_table.sv
source/dispatch.sv
source/fu_status_entry.sv
source/issue_select.sv
source/dispatch_top.sv
test/tb_dispatch_top.sv

/* source/dispatch.sv */
`timescale 1ns/10ps

module dispatch (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            instr_valid,
    input  logic                            fu_valid,
    input  logic [dispatch_pkg::FU_W-1:0]   fu_sel,
    input  logic [dispatch_pkg::REG_W-1:0]  rd,
    input  logic [dispatch_pkg::REG_W-1:0]  rs1,
    input  logic [dispatch_pkg::REG_W-1:0]  rs2,
    input  logic                            reg_write,
    input  logic                            cond_branch,
    input  logic [1:0]                      j_type,
    input  logic [dispatch_pkg::NUM_FU-1:0] fu_busy,
    input  dispatch_pkg::tag_t              rs1_tag,
    input  dispatch_pkg::tag_t              rs2_tag,
    input  logic                            rd_busy,
    input  logic                            wb_en,
    input  logic [dispatch_pkg::FU_W-1:0]   wb_fu,
    input  logic                            branch_resolved,
    input  logic                            branch_miss,
    output logic                            freeze,
    output logic [dispatch_pkg::NUM_FU-1:0] fu_en,
    output dispatch_pkg::tag_t              fu_t1,
    output dispatch_pkg::tag_t              fu_t2,
    output logic                            fu_spec,
    output logic                            mark_en,
    output dispatch_pkg::tag_t              mark_tag,
    output logic                            mark_spec
);
    import dispatch_pkg::*;

    logic struct_haz;
    logic waw_haz;
    logic hazard;
    logic accept;
    logic no_src;
    logic spec;
    tag_t wb_tag;
    tag_t t1_byp;
    tag_t t2_byp;

    // structural: the one entry of the target unit is still occupied
    assign struct_haz = fu_valid && fu_busy[fu_sel];
    assign waw_haz    = reg_write && rd_busy;
    assign hazard     = struct_haz || waw_haz;

    // a miss squashes this cycle, so nothing is accepted or held
    assign freeze = instr_valid && hazard && !branch_miss;
    assign accept = instr_valid && !hazard && !branch_miss;

    assign fu_en = (accept && fu_valid) ? (NUM_FU'(1) << fu_sel) : '0;

    // writeback in the same cycle would otherwise miss the new entry
    assign wb_tag = tag_t'(wb_fu + 2'd1);
    assign t1_byp = (wb_en && rs1_tag == wb_tag) ? TAG_READY : rs1_tag;
    assign t2_byp = (wb_en && rs2_tag == wb_tag) ? TAG_READY : rs2_tag;

    // jal carries only immediate bits in the source fields
    assign no_src = (j_type == 2'd1);
    assign fu_t1  = no_src ? TAG_READY : t1_byp;
    assign fu_t2  = no_src ? TAG_READY : t2_byp;

    assign fu_spec = spec && !(branch_resolved || branch_miss);

    assign mark_en   = accept && reg_write;
    assign mark_tag  = tag_t'(fu_sel + 2'd1);
    assign mark_spec = fu_spec;

    // speculation window opens behind an accepted conditional branch
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec <= 1'b0;
        end else if (branch_resolved || branch_miss) begin
            spec <= 1'b0;
        end else if (accept && cond_branch) begin
            spec <= 1'b1;
        end
    end

endmodule

/* source/dispatch_pkg.sv */
package dispatch_pkg;

    // instruction and register file geometry
    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;
    localparam int OP_W     = 4;

    // scalar function units, also the entry indices
    localparam int NUM_FU = 3;
    localparam int FU_W   = 2;

    localparam logic [FU_W-1:0] FU_ALU    = 2'd0;
    localparam logic [FU_W-1:0] FU_LD_ST  = 2'd1;
    localparam logic [FU_W-1:0] FU_BRANCH = 2'd2;

    // producer tag is unit index plus one, zero means value in register file
    typedef logic [1:0] tag_t;

    localparam tag_t TAG_READY = 2'd0;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // entry payload is {rd, rs1, rs2, imm, op, i_type, j_type}
    localparam int ENTRY_W = 3 * REG_W + WORD_W + OP_W + 1 + 2;

endpackage

/* source/dispatch_top.sv */
`timescale 1ns/10ps

module dispatch_top (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            instr_valid,
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    output logic                            freeze,
    input  logic                            branch_resolved,
    input  logic                            branch_miss,
    input  logic                            wb_en,
    input  logic [dispatch_pkg::FU_W-1:0]   wb_fu,
    input  logic [dispatch_pkg::REG_W-1:0]  wb_rd,
    output logic                            issue_valid,
    output logic [dispatch_pkg::FU_W-1:0]   issue_fu,
    output logic [dispatch_pkg::REG_W-1:0]  issue_rd,
    output logic [dispatch_pkg::REG_W-1:0]  issue_rs1,
    output logic [dispatch_pkg::REG_W-1:0]  issue_rs2,
    output logic [dispatch_pkg::WORD_W-1:0] issue_imm,
    output logic [dispatch_pkg::OP_W-1:0]   issue_op
);
    import dispatch_pkg::*;

    logic                             fu_valid;
    logic [FU_W-1:0]                  fu_sel;
    logic [REG_W-1:0]                 rd;
    logic [REG_W-1:0]                 rs1;
    logic [REG_W-1:0]                 rs2;
    logic [WORD_W-1:0]                imm;
    logic [OP_W-1:0]                  op;
    logic                             reg_write;
    logic                             i_type;
    logic [1:0]                       j_type;
    logic                             cond_branch;
    tag_t                             rs1_tag;
    tag_t                             rs2_tag;
    logic                             rd_busy;
    logic                             mark_en;
    tag_t                             mark_tag;
    logic                             mark_spec;
    logic [NUM_FU-1:0]                fu_en;
    tag_t                             fu_t1;
    tag_t                             fu_t2;
    logic                             fu_spec;
    logic [ENTRY_W-1:0]               fu_payload;
    tag_t                             wb_tag;
    logic [NUM_FU-1:0]                wb_free;
    logic [NUM_FU-1:0]                ent_busy;
    logic [NUM_FU-1:0]                ent_ready;
    logic [NUM_FU-1:0][ENTRY_W-1:0]   ent_payload;
    logic [NUM_FU-1:0]                issue_grant;

    assign fu_payload = {rd, rs1, rs2, imm, op, i_type, j_type};
    assign wb_tag     = tag_t'(wb_fu + 2'd1);
    assign wb_free    = NUM_FU'(wb_en) << wb_fu;

    instr_decoder i_decoder (
        .instr(instr), .fu_valid(fu_valid), .fu_sel(fu_sel), .rd(rd), .rs1(rs1),
        .rs2(rs2), .imm(imm), .op(op), .reg_write(reg_write), .i_type(i_type),
        .j_type(j_type), .cond_branch(cond_branch)
    );

    dispatch i_dispatch (
        .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .fu_valid(fu_valid),
        .fu_sel(fu_sel), .rd(rd), .rs1(rs1), .rs2(rs2), .reg_write(reg_write),
        .cond_branch(cond_branch), .j_type(j_type), .fu_busy(ent_busy),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rd_busy(rd_busy), .wb_en(wb_en),
        .wb_fu(wb_fu), .branch_resolved(branch_resolved), .branch_miss(branch_miss),
        .freeze(freeze), .fu_en(fu_en), .fu_t1(fu_t1), .fu_t2(fu_t2),
        .fu_spec(fu_spec), .mark_en(mark_en), .mark_tag(mark_tag), .mark_spec(mark_spec)
    );

    reg_status_table i_rst (
        .CLK(CLK), .nRST(nRST), .mark_en(mark_en), .mark_sel(rd), .mark_tag(mark_tag),
        .mark_spec(mark_spec), .wb_en(wb_en), .wb_sel(wb_rd), .wb_tag(wb_tag),
        .flush(branch_miss), .resolved(branch_resolved), .rs1_sel(rs1), .rs2_sel(rs2),
        .rd_sel(rd), .rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rd_busy(rd_busy)
    );

    // one status entry per unit, index equals unit number
    for (genvar i = 0; i < NUM_FU; i++) begin : g_entry
        fu_status_entry i_entry (
            .CLK(CLK), .nRST(nRST), .en(fu_en[i]), .payload_in(fu_payload),
            .t1_in(fu_t1), .t2_in(fu_t2), .spec_in(fu_spec), .grant(issue_grant[i]),
            .wb_en(wb_en), .wb_tag(wb_tag), .free(wb_free[i]), .branch_miss(branch_miss),
            .busy(ent_busy[i]), .ready(ent_ready[i]), .payload(ent_payload[i]), .spec()
        );
    end

    issue_select i_select (
        .ready(ent_ready), .payload(ent_payload), .issue_grant(issue_grant),
        .issue_valid(issue_valid), .issue_fu(issue_fu), .issue_rd(issue_rd),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_imm(issue_imm),
        .issue_op(issue_op)
    );

endmodule

/* source/fu_status_entry.sv */
`timescale 1ns/10ps

module fu_status_entry (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             en,
    input  logic [dispatch_pkg::ENTRY_W-1:0] payload_in,
    input  dispatch_pkg::tag_t               t1_in,
    input  dispatch_pkg::tag_t               t2_in,
    input  logic                             spec_in,
    input  logic                             grant,
    input  logic                             wb_en,
    input  dispatch_pkg::tag_t               wb_tag,
    input  logic                             free,
    input  logic                             branch_miss,
    output logic                             busy,
    output logic                             ready,
    output logic [dispatch_pkg::ENTRY_W-1:0] payload,
    output logic                             spec
);
    import dispatch_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_EXEC
    } state_t;

    state_t state;
    tag_t   t1;
    tag_t   t2;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= ST_IDLE;
            t1    <= TAG_READY;
            t2    <= TAG_READY;
            spec  <= 1'b0;
        end else if (en) begin
            state <= ST_WAIT;
            t1    <= t1_in;
            t2    <= t2_in;
            spec  <= spec_in;
        end else if ((branch_miss && spec) || free) begin
            // squashed or written back
            state <= ST_IDLE;
            spec  <= 1'b0;
        end else begin
            if (grant) begin
                state <= ST_EXEC;
            end
            if (wb_en && t1 == wb_tag) begin
                t1 <= TAG_READY;
            end
            if (wb_en && t2 == wb_tag) begin
                t2 <= TAG_READY;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (en) begin
            payload <= payload_in;
        end
    end

    assign busy  = (state != ST_IDLE);
    assign ready = (state == ST_WAIT) && (t1 == TAG_READY) && (t2 == TAG_READY);

endmodule

/* source/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    output logic                            fu_valid,
    output logic [dispatch_pkg::FU_W-1:0]   fu_sel,
    output logic [dispatch_pkg::REG_W-1:0]  rd,
    output logic [dispatch_pkg::REG_W-1:0]  rs1,
    output logic [dispatch_pkg::REG_W-1:0]  rs2,
    output logic [dispatch_pkg::WORD_W-1:0] imm,
    output logic [dispatch_pkg::OP_W-1:0]   op,
    output logic                            reg_write,
    output logic                            i_type,
    output logic [1:0]                      j_type,
    output logic                            cond_branch
);
    import dispatch_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       writes;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];

    // immediate forms hold no rs2, read x0 so no false dependency
    assign rs2 = i_type ? '0 : instr[24:20];

    assign reg_write   = writes && (rd != '0);
    assign cond_branch = (opcode == OPC_BRANCH);

    always_comb begin
        fu_valid = 1'b1;
        fu_sel   = FU_ALU;
        op       = {1'b0, funct3};
        writes   = 1'b0;
        i_type   = 1'b0;
        j_type   = 2'd0;
        // U immediate unless the format says otherwise
        imm      = {instr[31:12], 12'b0};
        case (opcode)
            OPC_OP: begin
                op     = {instr[30], funct3};
                writes = 1'b1;
            end
            OPC_OP_IMM: begin
                // only the right shifts keep the funct7 bit
                op     = {instr[30] && (funct3 == 3'b101), funct3};
                imm    = {{20{instr[31]}}, instr[31:20]};
                writes = 1'b1;
                i_type = 1'b1;
            end
            OPC_LOAD: begin
                fu_sel = FU_LD_ST;
                imm    = {{20{instr[31]}}, instr[31:20]};
                writes = 1'b1;
                i_type = 1'b1;
            end
            OPC_STORE: begin
                fu_sel = FU_LD_ST;
                imm    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                fu_sel = FU_BRANCH;
                imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                fu_sel = FU_BRANCH;
                imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
                writes = 1'b1;
                j_type = 2'd1;
            end
            OPC_JALR: begin
                fu_sel = FU_BRANCH;
                imm    = {{20{instr[31]}}, instr[31:20]};
                writes = 1'b1;
                i_type = 1'b1;
                j_type = 2'd2;
            end
            default: fu_valid = 1'b0;
        endcase
    end

endmodule

/* source/issue_select.sv */
`timescale 1ns/10ps

module issue_select (
    input  logic [dispatch_pkg::NUM_FU-1:0]                             ready,
    input  logic [dispatch_pkg::NUM_FU-1:0][dispatch_pkg::ENTRY_W-1:0] payload,
    output logic [dispatch_pkg::NUM_FU-1:0]                             issue_grant,
    output logic                                                        issue_valid,
    output logic [dispatch_pkg::FU_W-1:0]                               issue_fu,
    output logic [dispatch_pkg::REG_W-1:0]                              issue_rd,
    output logic [dispatch_pkg::REG_W-1:0]                              issue_rs1,
    output logic [dispatch_pkg::REG_W-1:0]                              issue_rs2,
    output logic [dispatch_pkg::WORD_W-1:0]                             issue_imm,
    output logic [dispatch_pkg::OP_W-1:0]                               issue_op
);
    import dispatch_pkg::*;

    logic [ENTRY_W-1:0] win;

    // scan from the top so the lowest ready index is left standing
    always_comb begin
        issue_grant = '0;
        issue_fu    = '0;
        for (int i = NUM_FU - 1; i >= 0; i--) begin
            if (ready[i]) begin
                issue_grant    = '0;
                issue_grant[i] = 1'b1;
                issue_fu       = FU_W'(i);
            end
        end
    end

    assign issue_valid = |ready;
    assign win         = payload[issue_fu];

    // low three bits are i_type and j_type, kept for the entry only
    assign {issue_rd, issue_rs1, issue_rs2, issue_imm, issue_op} = win[ENTRY_W-1:3];

endmodule

/* source/reg_status_table.sv */
`timescale 1ns/10ps

module reg_status_table (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           mark_en,
    input  logic [dispatch_pkg::REG_W-1:0] mark_sel,
    input  dispatch_pkg::tag_t             mark_tag,
    input  logic                           mark_spec,
    input  logic                           wb_en,
    input  logic [dispatch_pkg::REG_W-1:0] wb_sel,
    input  dispatch_pkg::tag_t             wb_tag,
    input  logic                           flush,
    input  logic                           resolved,
    input  logic [dispatch_pkg::REG_W-1:0] rs1_sel,
    input  logic [dispatch_pkg::REG_W-1:0] rs2_sel,
    input  logic [dispatch_pkg::REG_W-1:0] rd_sel,
    output dispatch_pkg::tag_t             rs1_tag,
    output dispatch_pkg::tag_t             rs2_tag,
    output logic                           rd_busy
);
    import dispatch_pkg::*;

    tag_t                tags [NUM_REGS];
    logic [NUM_REGS-1:0] spec_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                tags[i] <= TAG_READY;
            end
            spec_q <= '0;
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                // a new producer overrides any clear this cycle
                if (mark_en && mark_sel == REG_W'(i)) begin
                    tags[i]   <= mark_tag;
                    spec_q[i] <= mark_spec;
                end else if (flush && spec_q[i]) begin
                    tags[i]   <= TAG_READY;
                    spec_q[i] <= 1'b0;
                end else if (wb_en && wb_sel == REG_W'(i) && tags[i] == wb_tag) begin
                    tags[i]   <= TAG_READY;
                    spec_q[i] <= 1'b0;
                end else if (resolved) begin
                    spec_q[i] <= 1'b0;
                end
            end
        end
    end

    assign rs1_tag = tags[rs1_sel];
    assign rs2_tag = tags[rs2_sel];
    assign rd_busy = (tags[rd_sel] != TAG_READY);

endmodule

/* test/tb_dispatch_top.sv */
`timescale 1ns/10ps

module tb_dispatch_top;
    import dispatch_pkg::*;

    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_INSTRS = 18;
    localparam int RANDOM_INSTRS   = 40;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + 40 * (DIRECTED_INSTRS + RANDOM_INSTRS);
    localparam int ISSUE_W         = 3 * REG_W + WORD_W + OP_W;

    logic               CLK = 1'b0;
    logic               nRST;
    logic               instr_valid;
    logic [WORD_W-1:0]  instr;
    logic               freeze;
    logic               branch_resolved;
    logic               branch_miss;
    logic               wb_en;
    logic [FU_W-1:0]    wb_fu;
    logic [REG_W-1:0]   wb_rd;
    logic               issue_valid;
    logic [FU_W-1:0]    issue_fu;
    logic [REG_W-1:0]   issue_rd;
    logic [REG_W-1:0]   issue_rs1;
    logic [REG_W-1:0]   issue_rs2;
    logic [WORD_W-1:0]  issue_imm;
    logic [OP_W-1:0]    issue_op;

    // stimulus for the next falling edge
    logic               nx_valid;
    logic [WORD_W-1:0]  nx_instr;
    logic               nx_wb_en;
    logic [FU_W-1:0]    nx_wb_fu;
    logic [REG_W-1:0]   nx_wb_rd;
    logic               nx_res;
    logic               nx_miss;
    // fields of the word on the fetch port
    int                 pend_fu;
    logic [REG_W-1:0]   pend_rd;
    logic [REG_W-1:0]   pend_rs1;
    logic [REG_W-1:0]   pend_rs2;
    logic [ISSUE_W-1:0] pend_exp;
    logic               pend_rw;
    logic               pend_cond;
    // reference scoreboard, entry state 0 idle 1 waiting 2 executing
    int                 ent_state [NUM_FU];
    tag_t               ent_t1 [NUM_FU];
    tag_t               ent_t2 [NUM_FU];
    logic               ent_spec [NUM_FU];
    logic [ISSUE_W-1:0] ent_exp [NUM_FU];
    logic [REG_W-1:0]   ent_rd [NUM_FU];
    int                 exec_cnt [NUM_FU];
    tag_t               reg_tag [NUM_REGS];
    logic               reg_spec [NUM_REGS];
    logic               spec_q;
    logic               auto_exec;
    logic               last_accept;
    logic [31:0]        lfsr;
    int                 errors = 0;
    int                 test_start = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 cycles = 0;

    dispatch_top i_dut (
        .CLK(CLK), .nRST(nRST), .instr_valid(instr_valid), .instr(instr), .freeze(freeze),
        .branch_resolved(branch_resolved), .branch_miss(branch_miss), .wb_en(wb_en),
        .wb_fu(wb_fu), .wb_rd(wb_rd), .issue_valid(issue_valid), .issue_fu(issue_fu),
        .issue_rd(issue_rd), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .issue_imm(issue_imm), .issue_op(issue_op)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // fibonacci lfsr x^32+x^22+x^2+x+1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // kind 0 op-imm, 1 load, 2 store, else branch with imm as offset bits 12..1
    task automatic set_instr(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [11:0] imm,
                             input logic [2:0] f3);
        logic [WORD_W-1:0] sx;
        sx        = {{20{imm[11]}}, imm};
        pend_rd   = rd;
        pend_rs1  = rs1;
        pend_rs2  = (kind >= 2) ? rs2 : 5'd0;
        pend_rw   = (kind <= 1) && (rd != 5'd0);
        pend_cond = (kind >= 3);
        case (kind)
            0: begin
                nx_instr = {imm, rs1, f3, rd, OPC_OP_IMM};
                pend_fu  = FU_ALU;
                pend_exp = {rd, rs1, 5'd0, sx, imm[10] && f3 == 3'b101, f3};
            end
            1: begin
                nx_instr = {imm, rs1, f3, rd, OPC_LOAD};
                pend_fu  = FU_LD_ST;
                pend_exp = {rd, rs1, 5'd0, sx, 1'b0, f3};
            end
            2: begin
                nx_instr = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
                pend_fu  = FU_LD_ST;
                pend_exp = {imm[4:0], rs1, rs2, sx, 1'b0, f3};
            end
            default: begin
                nx_instr = {imm[11], imm[9:4], rs2, rs1, f3, imm[3:0], imm[10], OPC_BRANCH};
                pend_fu  = FU_BRANCH;
                pend_exp = {imm[3:0], imm[10], rs1, rs2, {19{imm[11]}}, imm, 1'b0, 1'b0, f3};
            end
        endcase
        nx_valid = 1'b1;
    endtask

    // execution stand-in, the lowest unit whose latency ran out writes back
    task automatic pick_writeback();
        for (int u = NUM_FU - 1; u >= 0; u--) begin
            if (ent_state[u] == 2 && exec_cnt[u] == 0) begin
                nx_wb_en = 1'b1;
                nx_wb_fu = FU_W'(u);
                nx_wb_rd = ent_rd[u];
            end else if (ent_state[u] == 2) begin
                exec_cnt[u]--;
            end
        end
        if (nx_wb_en && nx_wb_fu == FU_BRANCH) begin
            nx_miss = take_bits(1) != 0;
            nx_res  = !nx_miss;
        end
    endtask

    task automatic step();
        int   g;
        logic haz;
        logic acc;
        logic sp;
        tag_t wt;
        @(negedge CLK);
        if (auto_exec) begin
            pick_writeback();
        end
        instr_valid     = nx_valid;
        instr           = nx_instr;
        wb_en           = nx_wb_en;
        wb_fu           = nx_wb_fu;
        wb_rd           = nx_wb_rd;
        branch_resolved = nx_res;
        branch_miss     = nx_miss;
        #10;
        haz = ent_state[pend_fu] != 0 || (pend_rw && reg_tag[pend_rd] != TAG_READY);
        acc = nx_valid && !haz && !nx_miss;
        g   = -1;
        for (int u = NUM_FU - 1; u >= 0; u--) begin
            if (ent_state[u] == 1 && ent_t1[u] == TAG_READY && ent_t2[u] == TAG_READY) begin
                g = u;
            end
        end
        assert (freeze === (nx_valid && haz && !nx_miss)) else begin
            $display("Mismatch freeze: got %h expected %h", freeze, nx_valid && haz && !nx_miss);
            errors++;
        end
        assert (issue_valid === (g >= 0)) else begin
            $display("Mismatch issue_valid: got %h expected %h", issue_valid, g >= 0);
            errors++;
        end
        if (g >= 0) begin
            assert (issue_fu === FU_W'(g)) else begin
                $display("Mismatch issue_fu: got %h expected %h", issue_fu, FU_W'(g));
                errors++;
            end
            assert ({issue_rd, issue_rs1, issue_rs2, issue_imm, issue_op} === ent_exp[g]) else begin
                $display("Mismatch issue fields rd/rs1/rs2/imm/op: got %h expected %h",
                         {issue_rd, issue_rs1, issue_rs2, issue_imm, issue_op}, ent_exp[g]);
                errors++;
            end
        end
        // scoreboard state after the coming rising edge
        wt = tag_t'(nx_wb_fu + 2'd1);
        sp = spec_q && !(nx_res || nx_miss);
        for (int u = 0; u < NUM_FU; u++) begin
            if (acc && u == pend_fu) begin
                ent_state[u] = 1;
                ent_t1[u]    = (nx_wb_en && reg_tag[pend_rs1] == wt) ? TAG_READY : reg_tag[pend_rs1];
                ent_t2[u]    = (nx_wb_en && reg_tag[pend_rs2] == wt) ? TAG_READY : reg_tag[pend_rs2];
                ent_spec[u]  = sp;
                ent_exp[u]   = pend_exp;
                ent_rd[u]    = pend_rw ? pend_rd : 5'd0;
            end else if ((nx_miss && ent_spec[u]) || (nx_wb_en && nx_wb_fu == FU_W'(u))) begin
                ent_state[u] = 0;
                ent_spec[u]  = 1'b0;
            end else begin
                if (g == u) begin
                    ent_state[u] = 2;
                    exec_cnt[u]  = int'(take_bits(2));
                end
                if (nx_wb_en && ent_t1[u] == wt) begin
                    ent_t1[u] = TAG_READY;
                end
                if (nx_wb_en && ent_t2[u] == wt) begin
                    ent_t2[u] = TAG_READY;
                end
            end
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            if (acc && pend_rw && pend_rd == REG_W'(r)) begin
                reg_tag[r]  = tag_t'(pend_fu + 1);
                reg_spec[r] = sp;
            end else if ((nx_miss && reg_spec[r]) ||
                         (nx_wb_en && nx_wb_rd == REG_W'(r) && reg_tag[r] == wt)) begin
                reg_tag[r]  = TAG_READY;
                reg_spec[r] = 1'b0;
            end else if (nx_res) begin
                reg_spec[r] = 1'b0;
            end
        end
        spec_q      = (nx_res || nx_miss) ? 1'b0 : (spec_q || (acc && pend_cond));
        last_accept = acc;
        nx_valid    = nx_valid && !acc;
        nx_wb_en    = 1'b0;
        nx_res      = 1'b0;
        nx_miss     = 1'b0;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic dispatch_instr();
        do begin
            step();
        end while (!last_accept);
    endtask

    task automatic writeback(input int u);
        nx_wb_en = 1'b1;
        nx_wb_fu = FU_W'(u);
        nx_wb_rd = ent_rd[u];
        step();
    endtask

    // write back whatever executes until every unit is idle, then resolve
    task automatic retire_all();
        while (ent_state[0] != 0 || ent_state[1] != 0 || ent_state[2] != 0) begin
            for (int u = NUM_FU - 1; u >= 0; u--) begin
                if (ent_state[u] == 2) begin
                    nx_wb_en = 1'b1;
                    nx_wb_fu = FU_W'(u);
                    nx_wb_rd = ent_rd[u];
                end
            end
            step();
        end
        nx_res = 1'b1;
        step();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("test %0s: ok", name);
        end else begin
            tests_failed++;
            $display("test %0s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    initial begin
        nRST = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        branch_resolved = 1'b0;
        branch_miss = 1'b0;
        wb_en = 1'b0;
        wb_fu = '0;
        wb_rd = '0;
        {nx_valid, nx_instr, nx_wb_en, nx_wb_fu, nx_wb_rd, nx_res, nx_miss} = '0;
        {pend_rd, pend_rs1, pend_rs2, pend_exp, pend_rw, pend_cond} = '0;
        pend_fu = 0;
        spec_q = 1'b0;
        auto_exec = 1'b0;
        last_accept = 1'b0;
        lfsr = 32'h461b5ceb;
        for (int u = 0; u < NUM_FU; u++) begin
            {ent_state[u], exec_cnt[u]} = '0;
            {ent_t1[u], ent_t2[u], ent_spec[u], ent_exp[u], ent_rd[u]} = '0;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            reg_tag[r]  = TAG_READY;
            reg_spec[r] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        step();
        set_instr(0, 5'd1, 5'd2, 5'd0, 12'h7a5, 3'b101);
        dispatch_instr();
        set_instr(1, 5'd3, 5'd4, 5'd0, 12'h804, 3'b010);
        dispatch_instr();
        set_instr(3, 5'd0, 5'd5, 5'd6, 12'h9c3, 3'b001);
        dispatch_instr();
        retire_all();
        end_test("independent issue");

        set_instr(0, 5'd8, 5'd1, 5'd0, 12'h011, 3'b000);
        dispatch_instr();
        set_instr(0, 5'd9, 5'd2, 5'd0, 12'h022, 3'b100);
        run_cycles(3);
        writeback(FU_ALU);
        dispatch_instr();
        retire_all();
        end_test("structural hazard");

        // alu waits on a pending load, then reads one written back as it dispatches
        set_instr(1, 5'd10, 5'd3, 5'd0, 12'h030, 3'b010);
        dispatch_instr();
        set_instr(0, 5'd11, 5'd10, 5'd0, 12'hfff, 3'b000);
        dispatch_instr();
        run_cycles(3);
        writeback(FU_LD_ST);
        retire_all();
        set_instr(1, 5'd12, 5'd3, 5'd0, 12'h044, 3'b000);
        dispatch_instr();
        run_cycles(2);
        set_instr(0, 5'd13, 5'd12, 5'd0, 12'h5a5, 3'b101);
        writeback(FU_LD_ST);
        retire_all();
        end_test("raw and bypass");

        set_instr(0, 5'd14, 5'd1, 5'd0, 12'h100, 3'b110);
        dispatch_instr();
        set_instr(1, 5'd14, 5'd2, 5'd0, 12'h008, 3'b010);
        run_cycles(3);
        writeback(FU_ALU);
        dispatch_instr();
        retire_all();
        end_test("waw hazard");

        // the load keeps the speculative alu waiting so the miss catches it
        set_instr(1, 5'd16, 5'd1, 5'd0, 12'h010, 3'b010);
        dispatch_instr();
        set_instr(3, 5'd0, 5'd2, 5'd3, 12'h0f4, 3'b000);
        dispatch_instr();
        set_instr(0, 5'd15, 5'd16, 5'd0, 12'h123, 3'b000);
        dispatch_instr();
        run_cycles(2);
        set_instr(0, 5'd15, 5'd0, 5'd0, 12'h321, 3'b111);
        nx_miss = 1'b1;
        step();
        writeback(FU_LD_ST);
        retire_all();
        set_instr(1, 5'd17, 5'd1, 5'd0, 12'h020, 3'b010);
        dispatch_instr();
        set_instr(3, 5'd0, 5'd4, 5'd5, 12'h80c, 3'b101);
        dispatch_instr();
        set_instr(0, 5'd18, 5'd17, 5'd0, 12'h456, 3'b001);
        dispatch_instr();
        nx_res = 1'b1;
        step();
        writeback(FU_LD_ST);
        retire_all();
        end_test("speculation");

        auto_exec = 1'b1;
        repeat (RANDOM_INSTRS) begin
            set_instr(int'(take_bits(2)), REG_W'(take_bits(3)), REG_W'(take_bits(3)),
                      REG_W'(take_bits(3)), 12'(take_bits(12)), 3'(take_bits(3)));
            dispatch_instr();
        end
        auto_exec = 1'b0;
        retire_all();
        end_test("random mix");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
